// ==== source/cache_axi_pkg.sv ====
/*
 * cache write back end shared definitions
 * bus widths, payload types and AXI write response codes
 */
package cache_axi_pkg;

   localparam int ADDR_W        = 32;                   // byte address
   localparam int DATA_W        = 32;                   // bus word = cache word
   localparam int NBYTES        = DATA_W / 8;
   localparam int WORD_OFFSET_W = 2;                    // log2 words per line
   localparam int LINE_WORDS    = 2 ** WORD_OFFSET_W;

   // one bus word and its byte strobes
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [NBYTES-1:0] strb_t;

   typedef logic [ADDR_W-1:0] addr_t;

   // evicted line, word 0 sits in the low bits
   typedef word_t [LINE_WORDS-1:0] line_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10                                    // retried by the channel
   } resp_e;

endpackage

// ==== source/axi_write_if.sv ====
`timescale 1ns/1ns
/*
 * AXI4 write port bundle (AW, W and B channels)
 * ids, size, burst and cache attributes are constant and left out
 */
interface axi_write_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);

   // address channel
   logic [ADDR_W-1:0]   awaddr;
   logic [7:0]          awlen;     // beats minus one
   logic                awvalid;
   logic                awready;

   // data channel
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic                wlast;
   logic                wvalid;
   logic                wready;

   // response channel
   logic [1:0]          bresp;
   logic                bvalid;
   logic                bready;

   modport master (
      output awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
      input  awready, wready, bresp, bvalid
   );

   modport slave (
      input  awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
      output awready, wready, bresp, bvalid
   );

endinterface

// ==== source/cache_write_channel.sv ====
`timescale 1ns/1ns
/*
 * cache write channel that turns one request into one AXI4 write transaction
 * idle, address, write, verify FSM that resends the whole burst on SLVERR
 */
module cache_write_channel
   import cache_axi_pkg::*;
#(
   parameter type payload_t = word_t,
   parameter int  ADDR_W    = cache_axi_pkg::ADDR_W,
   parameter int  DATA_W    = cache_axi_pkg::DATA_W
) (
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     valid_i,
   input  addr_t    addr_i,
   input  payload_t wdata_i,
   input  strb_t    wstrb_i,
   output logic     ready_o,
   axi_write_if.master axi
);

   // burst shape follows the payload width
   localparam int PAYLOAD_W = $bits(payload_t);
   localparam int BEATS     = PAYLOAD_W / DATA_W;
   localparam bit IS_LINE   = (BEATS > 1);
   localparam int BEAT_W    = IS_LINE ? $clog2(BEATS) : 1;
   localparam int STRB_W    = DATA_W / 8;
   localparam int ALIGN_W   = $clog2(BEATS * STRB_W);  // low address bits cleared

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_write,
      st_verif
   } state_e;

   state_e                state;
   state_e                state_nxt;
   logic [BEAT_W-1:0]     beat_cnt;       // current beat inside the burst
   logic [PAYLOAD_W-1:0]  payload_bits;
   logic                  last_beat;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  b_hs;
   logic                  b_okay;
   logic [8:0]            w_seen;         // beats accepted since the AW handshake

   assign payload_bits = wdata_i;
   assign last_beat    = (beat_cnt == BEAT_W'(BEATS - 1));

   assign aw_hs  = axi.awvalid & axi.awready;
   assign w_hs   = axi.wvalid & axi.wready;
   assign b_hs   = axi.bvalid & axi.bready;
   assign b_okay = b_hs & (axi.bresp == OKAY);

   // address and data come straight from the held request
   assign axi.awaddr = {addr_i[ADDR_W-1:ALIGN_W], {ALIGN_W{1'b0}}};  // word or line aligned
   assign axi.awlen  = 8'(BEATS - 1);
   assign axi.wdata  = payload_bits[beat_cnt * DATA_W +: DATA_W];
   assign axi.wstrb  = IS_LINE ? {STRB_W{1'b1}} : wstrb_i;          // lines write every byte
   assign axi.wlast  = axi.wvalid & last_beat;

   assign axi.awvalid = (state == st_addr);
   assign axi.wvalid  = (state == st_write);
   assign axi.bready  = (state == st_verif);

   always_comb begin
      ready_o = 1'b0;
      case (state)
         st_idle:  ready_o = IS_LINE ? ~valid_i : 1'b1;
         st_verif: ready_o = b_okay;              // completion pulse
         default:  ready_o = 1'b0;
      endcase
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (valid_i) state_nxt = st_addr;
         end
         st_addr: begin
            if (axi.awready) state_nxt = st_write;
         end
         st_write: begin
            if (w_hs && last_beat) state_nxt = st_verif;
         end
         st_verif: begin
            if (b_hs) begin
               if (!b_okay)
                  state_nxt = st_addr;            // error response resends it all
               else
                  state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state    <= st_idle;
         beat_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (w_hs) beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
   end

   // independent beat count for the wlast check
   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i)
         w_seen <= '0;
      else if (aw_hs)
         w_seen <= '0;
      else if (w_hs)
         w_seen <= w_seen + 1'b1;
   end

   a_awvalid_hold: assert property (
      @(posedge clk_i) disable iff (reset_i)
      axi.awvalid && !axi.awready |=> axi.awvalid && $stable(axi.awaddr)
   ) else $error("awvalid or awaddr changed before awready");

   a_wlast_final: assert property (
      @(posedge clk_i) disable iff (reset_i)
      w_hs |-> (axi.wlast == (w_seen == 9'(BEATS - 1)))
   ) else $error("wlast not on the final beat of the burst");

endmodule

// ==== source/axi_write_arbiter.sv ====
`timescale 1ns/1ns
/*
 * AXI4 write arbiter for the word and line channels
 * one owner per transaction, round robin when both ask at once
 */
module axi_write_arbiter #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                reset_i,
   axi_write_if.slave          wt,
   axi_write_if.slave          wb,
   output logic [ADDR_W-1:0]   axi_awaddr_o,
   output logic [7:0]          axi_awlen_o,
   output logic                axi_awvalid_o,
   input  logic                axi_awready_i,
   output logic [DATA_W-1:0]   axi_wdata_o,
   output logic [DATA_W/8-1:0] axi_wstrb_o,
   output logic                axi_wlast_o,
   output logic                axi_wvalid_o,
   input  logic                axi_wready_i,
   input  logic [1:0]          axi_bresp_i,
   input  logic                axi_bvalid_i,
   output logic                axi_bready_o
);

   logic busy;        // port granted until the B handshake
   logic owner_wb;    // line channel owns the port, kept as last winner once free
   logic pick_wb;
   logic b_hs;
   logic b_pending;   // AW accepted, B not yet seen

   // line channel wins a tie unless it won the previous grant
   assign pick_wb = wb.awvalid & (~wt.awvalid | ~owner_wb);
   assign b_hs    = axi_bvalid_i & axi_bready_o;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         busy     <= 1'b0;
         owner_wb <= 1'b0;    // so the line channel goes first
      end else if (!busy) begin
         if (wt.awvalid | wb.awvalid) begin
            busy     <= 1'b1;
            owner_wb <= pick_wb;
         end
      end else if (b_hs) begin
         busy <= 1'b0;
      end
   end

   // master side, taken from the owner
   assign axi_awaddr_o  = owner_wb ? wb.awaddr : wt.awaddr;
   assign axi_awlen_o   = owner_wb ? wb.awlen : wt.awlen;
   assign axi_awvalid_o = busy & (owner_wb ? wb.awvalid : wt.awvalid);
   assign axi_wdata_o   = owner_wb ? wb.wdata : wt.wdata;
   assign axi_wstrb_o   = owner_wb ? wb.wstrb : wt.wstrb;
   assign axi_wlast_o   = owner_wb ? wb.wlast : wt.wlast;
   assign axi_wvalid_o  = busy & (owner_wb ? wb.wvalid : wt.wvalid);
   assign axi_bready_o  = busy & (owner_wb ? wb.bready : wt.bready);

   // slave side, the non-owner sees no handshakes
   assign wt.awready = busy & ~owner_wb & axi_awready_i;
   assign wt.wready  = busy & ~owner_wb & axi_wready_i;
   assign wt.bvalid  = busy & ~owner_wb & axi_bvalid_i;
   assign wt.bresp   = axi_bresp_i;

   assign wb.awready = busy & owner_wb & axi_awready_i;
   assign wb.wready  = busy & owner_wb & axi_wready_i;
   assign wb.bvalid  = busy & owner_wb & axi_bvalid_i;
   assign wb.bresp   = axi_bresp_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i)
         b_pending <= 1'b0;
      else if (axi_awvalid_o && axi_awready_i)
         b_pending <= 1'b1;
      else if (b_hs)
         b_pending <= 1'b0;
   end

   a_one_outstanding: assert property (
      @(posedge clk_i) disable iff (reset_i)
      b_pending |-> !axi_awvalid_o
   ) else $error("new AW issued while a B response is pending");

endmodule

// ==== source/cache_write_backend.sv ====
`timescale 1ns/1ns
/*
 * cache write back end, write-through stores and line evictions
 * share one AXI4 write port through the arbiter
 */
module cache_write_backend
   import cache_axi_pkg::*;
#(
   parameter int ADDR_W = cache_axi_pkg::ADDR_W,
   parameter int DATA_W = cache_axi_pkg::DATA_W
) (
   input  logic                clk_i,
   input  logic                reset_i,
   // write-through word stores
   input  logic                wt_valid_i,
   input  addr_t               wt_addr_i,
   input  word_t               wt_wdata_i,
   input  strb_t               wt_wstrb_i,
   output logic                wt_ready_o,
   // write-back line evictions
   input  logic                wb_valid_i,
   input  addr_t               wb_addr_i,
   input  line_t               wb_wdata_i,
   output logic                wb_ready_o,
   // AXI4 write port
   output logic [ADDR_W-1:0]   axi_awaddr_o,
   output logic [7:0]          axi_awlen_o,
   output logic                axi_awvalid_o,
   input  logic                axi_awready_i,
   output logic [DATA_W-1:0]   axi_wdata_o,
   output logic [DATA_W/8-1:0] axi_wstrb_o,
   output logic                axi_wlast_o,
   output logic                axi_wvalid_o,
   input  logic                axi_wready_i,
   input  logic [1:0]          axi_bresp_i,
   input  logic                axi_bvalid_i,
   output logic                axi_bready_o
);

   axi_write_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wt_if ();
   axi_write_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wb_if ();

   cache_write_channel #(
      .payload_t (word_t),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) u_wt_channel (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (wt_valid_i),
      .addr_i  (wt_addr_i),
      .wdata_i (wt_wdata_i),
      .wstrb_i (wt_wstrb_i),
      .ready_o (wt_ready_o),
      .axi     (wt_if.master)
   );

   // evictions always write full lines, the strobe input is unused there
   cache_write_channel #(
      .payload_t (line_t),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) u_wb_channel (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (wb_valid_i),
      .addr_i  (wb_addr_i),
      .wdata_i (wb_wdata_i),
      .wstrb_i ('1),
      .ready_o (wb_ready_o),
      .axi     (wb_if.master)
   );

   axi_write_arbiter #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_arbiter (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .wt            (wt_if.slave),
      .wb            (wb_if.slave),
      .axi_awaddr_o  (axi_awaddr_o),
      .axi_awlen_o   (axi_awlen_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_wdata_o   (axi_wdata_o),
      .axi_wstrb_o   (axi_wstrb_o),
      .axi_wlast_o   (axi_wlast_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bresp_i   (axi_bresp_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o)
   );

endmodule

// ==== verification/axi_mem_model.sv ====
`timescale 1ns/1ns
/*
 * AXI4 write slave memory for the testbench
 * stalls AW and W on request and answers every seventh response with SLVERR
 */
module axi_mem_model
   import cache_axi_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic [1:0]  stall_i,     // bit 0 holds off awready, bit 1 wready
   input  logic [31:0] awaddr_i,
   input  logic        awvalid_i,
   output logic        awready_o,
   input  logic [31:0] wdata_i,
   input  logic [3:0]  wstrb_i,
   input  logic        wlast_i,
   input  logic        wvalid_i,
   output logic        wready_o,
   output logic [1:0]  bresp_o,
   output logic        bvalid_o,
   input  logic        bready_i
);

   logic [7:0] mem [0:1023];
   logic [1:0] phase;               // 0 address, 1 data, 2 response
   logic [9:0] base;
   int         beat;
   int         resp_cnt;

   initial begin
      for (int a = 0; a < 1024; a++) mem[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
   end

   always @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         bresp_o   <= OKAY;
         phase     <= 2'd0;
         resp_cnt  <= 0;
      end else begin
         case (phase)
            2'd0: begin
               awready_o <= ~stall_i[0];
               if (awvalid_i && awready_o) begin
                  awready_o <= 1'b0;
                  base      <= awaddr_i[9:0];
                  beat      <= 0;
                  phase     <= 2'd1;
               end
            end
            2'd1: begin
               wready_o <= ~stall_i[1];
               if (wvalid_i && wready_o) begin
                  for (int i = 0; i < 4; i++)
                     if (wstrb_i[i]) mem[10'(base + beat * 4 + i)] <= wdata_i[8*i +: 8];
                  beat <= beat + 1;
                  if (wlast_i) begin
                     wready_o <= 1'b0;
                     bvalid_o <= 1'b1;
                     bresp_o  <= (resp_cnt == 6) ? SLVERR : OKAY;
                     resp_cnt <= (resp_cnt == 6) ? 0 : resp_cnt + 1;
                     phase    <= 2'd2;
                  end
               end
            end
            default: begin
               if (bready_i) begin   // bvalid is high here
                  bvalid_o <= 1'b0;
                  phase    <= 2'd0;
               end
            end
         endcase
      end
   end

endmodule

// ==== verification/tb_cache_write_backend.sv ====
`timescale 1ns/1ns
/*
 * testbench for the cache write back end
 * word and line streams against a stalling AXI memory with a shadow memory compare
 */
module tb_cache_write_backend
   import cache_axi_pkg::*;
;
   localparam int NREQ       = 20;       // per stream
   localparam int MAX_CYCLES = 3000;     // 40 requests at about 60 cycles each, plus drain

   logic clk_i, reset_i;
   logic wt_valid_i, wt_ready_o, wb_valid_i, wb_ready_o;
   addr_t wt_addr_i, wb_addr_i;
   word_t wt_wdata_i;
   strb_t wt_wstrb_i;
   line_t wb_wdata_i;
   logic [31:0] axi_awaddr_o, axi_wdata_o;
   logic [7:0]  axi_awlen_o;
   logic [3:0]  axi_wstrb_o;
   logic [1:0]  axi_bresp_i, stall;
   logic axi_awvalid_o, axi_awready_i, axi_wlast_o, axi_wvalid_o, axi_wready_i;
   logic axi_bvalid_i, axi_bready_o;

   logic [7:0]  shadow [0:1023];
   logic [31:0] rnd_wt, rnd_wb, rnd_st, cur_addr, err_addr;
   logic [7:0]  cur_len, last_len, err_len, tie_len;
   int  check_errs, mem_errs, cycles, beat, wt_done, wb_done, idle_run;
   bit  outstanding, port_free, err_pending, tie_pending;

   cache_write_backend #(.ADDR_W(32), .DATA_W(32)) DUT (.*);

   axi_mem_model u_mem (
      .clk_i (clk_i), .reset_i (reset_i), .stall_i (stall),
      .awaddr_i (axi_awaddr_o), .awvalid_i (axi_awvalid_o),
      .awready_o (axi_awready_i), .wdata_i (axi_wdata_o), .wstrb_i (axi_wstrb_o),
      .wlast_i (axi_wlast_o), .wvalid_i (axi_wvalid_o), .wready_o (axi_wready_i),
      .bresp_o (axi_bresp_i), .bvalid_o (axi_bvalid_i),
      .bready_i (axi_bready_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic flag_error(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      check_errs++;
   endtask

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      rnd_st = xorshift(rnd_st);
      stall <= rnd_st[1:0];
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i)
      axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
      else flag_error("awvalid or awaddr changed before awready");

   // port monitor checks against the held requests
   always @(posedge clk_i) begin
      if (!reset_i) begin
         if (port_free && DUT.wt_if.awvalid && DUT.wb_if.awvalid) begin
            tie_pending = 1'b1;
            tie_len     = (last_len == 8'd3) ? 8'd0 : 8'd3;
         end
         if (port_free && (DUT.wt_if.awvalid || DUT.wb_if.awvalid)) port_free = 1'b0;
         if (axi_awvalid_o && outstanding) flag_error("AW issued with a transaction outstanding");
         if (axi_awvalid_o && axi_awready_i) begin
            if (axi_awlen_o == 8'd0)
               assert (axi_awaddr_o == {wt_addr_i[31:2], 2'b00}) else flag_error("word awaddr");
            else if (axi_awlen_o == 8'd3)
               assert (axi_awaddr_o == {wb_addr_i[31:4], 4'h0}) else flag_error("line awaddr");
            else
               flag_error("awlen is neither 0 nor 3");
            if (err_pending && axi_awlen_o == err_len) begin
               assert (axi_awaddr_o == err_addr) else flag_error("retry went to a new address");
               err_pending = 1'b0;
            end
            if (tie_pending) begin
               assert (axi_awlen_o == tie_len) else flag_error("grant did not alternate");
               tie_pending = 1'b0;
            end
            cur_len     = axi_awlen_o;
            last_len    = axi_awlen_o;
            cur_addr    = axi_awaddr_o;
            beat        = 0;
            outstanding = 1'b1;
         end
         if (axi_wvalid_o && axi_wready_i) begin
            if (!outstanding) flag_error("W beat with no AW accepted");
            assert (axi_wlast_o == (beat == cur_len)) else flag_error("wlast on wrong beat");
            if (cur_len == 8'd0)
               assert (axi_wdata_o == wt_wdata_i && axi_wstrb_o == wt_wstrb_i)
                  else flag_error("word beat data or strobes");
            else
               assert (axi_wdata_o == wb_wdata_i[beat] && axi_wstrb_o == 4'hf)
                  else flag_error("line beat data or strobes");
            beat++;
         end
         if (axi_bvalid_i && axi_bready_o) begin
            outstanding = 1'b0;
            port_free   = 1'b1;
            if (axi_bresp_i == SLVERR) begin
               assert (cur_len == 8'd0 ? !wt_ready_o : !wb_ready_o)
                  else flag_error("ready_o pulsed for a failed write");
               err_pending = 1'b1;
               err_len     = cur_len;
               err_addr    = cur_addr;
            end else if (cur_len == 8'd0) begin
               if (wt_ready_o) wt_done++;
               else flag_error("no wt_ready_o pulse for a completed store");
            end else begin
               if (wb_ready_o) wb_done++;
               else flag_error("no wb_ready_o pulse for a completed eviction");
            end
         end
      end
   end

   task automatic run_word_stream();
      logic [31:0] a;
      int n;
      for (int k = 0; k < NREQ; k++) begin
         rnd_wt = xorshift(rnd_wt);
         a      = {22'd0, rnd_wt[9:0]};
         wt_valid_i <= 1'b1;
         wt_addr_i  <= a;
         wt_wstrb_i <= rnd_wt[13:10];
         rnd_wt = xorshift(rnd_wt);
         wt_wdata_i <= rnd_wt;
         n = 0;
         do begin
            @(posedge clk_i);
            n++;
         end while (!(wt_ready_o && n > 1));
         for (int i = 0; i < 4; i++)
            if (wt_wstrb_i[i]) shadow[{a[9:2], 2'b00} + i] = wt_wdata_i[8*i +: 8];
      end
      wt_valid_i <= 1'b0;
   endtask

   task automatic run_line_stream();
      logic [31:0] a;
      line_t ln;
      int n;
      for (int k = 0; k < NREQ; k++) begin
         rnd_wb = xorshift(rnd_wb);
         a      = {22'd0, rnd_wb[9:0]};
         for (int w = 0; w < 4; w++) begin
            rnd_wb = xorshift(rnd_wb);
            ln[w]  = rnd_wb;
         end
         wb_valid_i <= 1'b1;
         wb_addr_i  <= a;
         wb_wdata_i <= ln;
         n = 0;
         do begin
            @(posedge clk_i);
            n++;
         end while (!(wb_ready_o && n > 1));
         for (int w = 0; w < 4; w++)
            for (int i = 0; i < 4; i++)
               shadow[{a[9:4], 4'h0} + 4 * w + i] = ln[w][8*i +: 8];
         rnd_wb = xorshift(rnd_wb);
         if (rnd_wb[1:0] != 2'd0) begin   // random gap between evictions
            wb_valid_i <= 1'b0;
            repeat (rnd_wb[1:0]) @(posedge clk_i);
         end
      end
      wb_valid_i <= 1'b0;
   endtask

   initial begin
      wt_valid_i = 1'b0;
      wt_addr_i  = '0;
      wt_wdata_i = '0;
      wt_wstrb_i = '0;
      wb_valid_i = 1'b0;
      wb_addr_i  = '0;
      wb_wdata_i = '0;
      stall = 2'b00;
      rnd_wt = 32'd85848;
      rnd_wb = 32'd85848 ^ 32'h9e3779b9;
      rnd_st = 32'd85848 ^ 32'h7f4a7c15;
      port_free = 1'b1;
      last_len  = 8'd0;                   // line channel wins the first tie
      for (int a = 0; a < 1024; a++) shadow[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
      reset_i = 1'b1;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i);
      assert (!axi_awvalid_o && !axi_wvalid_o && !axi_bready_o)
         else flag_error("AXI valids or bready high after reset");
      assert (wt_ready_o && wb_ready_o) else flag_error("ready_o low after reset");
      fork
         run_word_stream();
         run_line_stream();
      join
      idle_run = 0;
      while (idle_run < 3) begin
         @(posedge clk_i);
         if (wt_ready_o && wb_ready_o && !axi_awvalid_o && !outstanding) idle_run++;
         else idle_run = 0;
      end
      for (int a = 0; a < 1024; a++)
         if (u_mem.mem[a] !== shadow[a]) begin
            $display("FAIL %0t: memory byte %0h is %0h, expected %0h",
                     $time, a, u_mem.mem[a], shadow[a]);
            mem_errs++;
         end
      if (wt_done != NREQ || wb_done != NREQ) flag_error("ready_o pulse count mismatch");
      $display("checks failed: %0d, memory mismatches: %0d, requests done: %0d words, %0d lines",
               check_errs, mem_errs, wt_done, wb_done);
      if (check_errs == 0 && mem_errs == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== vlog.f ====
source/cache_axi_pkg.sv
source/axi_write_if.sv
source/cache_write_channel.sv
source/axi_write_arbiter.sv
source/cache_write_backend.sv
verification/axi_mem_model.sv
verification/tb_cache_write_backend.sv

// ==== Bender.yml ====
package:
  name: cache_write_backend

sources:
  - source/cache_axi_pkg.sv
  - source/axi_write_if.sv
  - source/cache_write_channel.sv
  - source/axi_write_arbiter.sv
  - source/cache_write_backend.sv
  - target: test
    files:
      - verification/axi_mem_model.sv
      - verification/tb_cache_write_backend.sv
